/* verilog/core_pkg.sv */
// ==================================================
// shared definitions of the issue core: data word,
// ALU opcodes and the fixed slot and lane counts
// ==================================================
`default_nettype none

package core_pkg;

	// the machine word carried by registers, immediates and results
	typedef logic [31:0] value_t;

	// operations understood by the integer ALUs
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5
	} opcode_t;

	// renamed micro-ops that may enter the reorder buffer in one cycle
	localparam int ENQ_WIDTH = 2;

	// integer ALUs fed by the oldest-first selection
	localparam int NUM_LANES = 2;

endpackage

`default_nettype wire

/* verilog/rob_ctrl.sv */
// ==================================================
// reorder buffer control: head/tail pointers, enqueue
// acceptance, oldest-first issue and in-order retire
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module rob_ctrl #(
	parameter int ROB_ENTRIES = 16,
	localparam int RW = $clog2(ROB_ENTRIES)
) (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic [core_pkg::ENQ_WIDTH-1:0]    enq_v_i,
	input  logic [ROB_ENTRIES-1:0]            could_issue_i,
	input  logic [ROB_ENTRIES-1:0]            done_i,
	output logic                              enq_ready_o,
	output logic [core_pkg::ENQ_WIDTH-1:0]    enq_we_o,
	output logic [RW-1:0]                     enq_idx_o [core_pkg::ENQ_WIDTH],
	output logic [core_pkg::NUM_LANES-1:0]    issue_v_o,
	output logic [RW-1:0]                     issue_idx_o [core_pkg::NUM_LANES],
	output logic [RW-1:0]                     head_idx_o,
	output logic                              retire_o
);
	import core_pkg::*;

	// head is the oldest entry, tail the next free one
	logic [RW-1:0] head;
	logic [RW-1:0] tail;
	// count needs one more bit than an index so a full buffer is visible
	logic [RW:0]   count;
	logic [RW:0]   num_enq;

	// ==================================================
	// enqueue
	// ==================================================

	// accept only when a whole group of slots is guaranteed to fit
	assign enq_ready_o = (int'(count) + ENQ_WIDTH <= ROB_ENTRIES);

	// valid slots are packed onto consecutive tail entries in slot order,
	// so an invalid slot leaves no hole in the buffer
	always_comb begin
		num_enq = '0;
		for (int s = 0; s < ENQ_WIDTH; s++) begin
			enq_we_o[s]  = enq_ready_o & enq_v_i[s];
			enq_idx_o[s] = tail + num_enq[RW-1:0];
			num_enq      = num_enq + (RW+1)'(enq_we_o[s]);
		end
	end

	// ==================================================
	// issue selection
	// ==================================================

	// scan from head so the oldest issuable entry goes to lane 0 and the
	// next one to lane 1; the index wraps with the power-of-two size
	always_comb begin
		int            found;
		logic [RW-1:0] idx;
		found = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			issue_v_o[l]   = 1'b0;
			issue_idx_o[l] = '0;
		end
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			idx = head + RW'(i);
			if (could_issue_i[idx] && found < NUM_LANES) begin
				issue_v_o[found]   = 1'b1;
				issue_idx_o[found] = idx;
				found              = found + 1;
			end
		end
	end

	// ==================================================
	// retire and pointer update
	// ==================================================

	// done_i is already qualified with the entry's valid bit
	assign retire_o   = done_i[head];
	assign head_idx_o = head;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= head + RW'(retire_o);
			tail  <= tail + num_enq[RW-1:0];
			count <= count + num_enq - (RW+1)'(retire_o);
		end
	end

endmodule

`default_nettype wire

/* verilog/rob_entries.sv */
// ==================================================
// reorder buffer entries: enqueue writes, operand
// wakeup on writeback, issue and done marking
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module rob_entries #(
	parameter int ROB_ENTRIES = 16,
	parameter int NPREG = 64,
	localparam int RW = $clog2(ROB_ENTRIES),
	localparam int PW = $clog2(NPREG)
) (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic [core_pkg::ENQ_WIDTH-1:0]    enq_we_i,
	input  logic [RW-1:0]                     enq_idx_i [core_pkg::ENQ_WIDTH],
	input  core_pkg::opcode_t                 enq_op_i [core_pkg::ENQ_WIDTH],
	input  logic [PW-1:0]                     enq_rd_i [core_pkg::ENQ_WIDTH],
	input  logic [PW-1:0]                     enq_ra_i [core_pkg::ENQ_WIDTH],
	input  logic [PW-1:0]                     enq_rb_i [core_pkg::ENQ_WIDTH],
	input  logic [core_pkg::ENQ_WIDTH-1:0]    enq_use_imm_i,
	input  core_pkg::value_t                  enq_imm_i [core_pkg::ENQ_WIDTH],
	input  logic [NPREG-1:0]                  rf_valid_i,
	input  logic [core_pkg::NUM_LANES-1:0]    issue_v_i,
	input  logic [RW-1:0]                     issue_idx_i [core_pkg::NUM_LANES],
	input  logic [core_pkg::NUM_LANES-1:0]    wb_v_i,
	input  logic [PW-1:0]                     wb_rd_i [core_pkg::NUM_LANES],
	input  logic [RW-1:0]                     wb_idx_i [core_pkg::NUM_LANES],
	input  logic                              retire_i,
	input  logic [RW-1:0]                     head_idx_i,
	output logic [ROB_ENTRIES-1:0]            could_issue_o,
	output logic [ROB_ENTRIES-1:0]            done_o,
	output core_pkg::opcode_t                 lane_op_o [core_pkg::NUM_LANES],
	output logic [PW-1:0]                     lane_rd_o [core_pkg::NUM_LANES],
	output logic [PW-1:0]                     lane_ra_o [core_pkg::NUM_LANES],
	output logic [PW-1:0]                     lane_rb_o [core_pkg::NUM_LANES],
	output logic [core_pkg::NUM_LANES-1:0]    lane_use_imm_o,
	output core_pkg::value_t                  lane_imm_o [core_pkg::NUM_LANES],
	output logic [PW-1:0]                     head_rd_o
);
	import core_pkg::*;

	// entry state: occupied, sent to a lane, result written back
	logic [ROB_ENTRIES-1:0] valid;
	logic [ROB_ENTRIES-1:0] issued;
	logic [ROB_ENTRIES-1:0] done;
	// operand readiness per entry
	logic [ROB_ENTRIES-1:0] arg_a_v;
	logic [ROB_ENTRIES-1:0] arg_b_v;
	// micro-op payload
	opcode_t                op [ROB_ENTRIES];
	logic [PW-1:0]          rd [ROB_ENTRIES];
	logic [PW-1:0]          ra [ROB_ENTRIES];
	logic [PW-1:0]          rb [ROB_ENTRIES];
	logic [ROB_ENTRIES-1:0] use_imm;
	value_t                 imm [ROB_ENTRIES];
	// readiness of each slot's sources as it enters
	logic [ENQ_WIDTH-1:0]   enq_a_rdy;
	logic [ENQ_WIDTH-1:0]   enq_b_rdy;

	// ==================================================
	// readiness at enqueue
	// ==================================================

	// a source is ready if the register is valid or is being written back
	// this cycle, but never when an older slot of the same group produces it
	always_comb begin
		for (int s = 0; s < ENQ_WIDTH; s++) begin
			enq_a_rdy[s] = rf_valid_i[enq_ra_i[s]];
			enq_b_rdy[s] = rf_valid_i[enq_rb_i[s]];
			for (int l = 0; l < NUM_LANES; l++) begin
				if (wb_v_i[l] && wb_rd_i[l] == enq_ra_i[s])
					enq_a_rdy[s] = 1'b1;
				if (wb_v_i[l] && wb_rd_i[l] == enq_rb_i[s])
					enq_b_rdy[s] = 1'b1;
			end
			for (int p = 0; p < s; p++) begin
				if (enq_we_i[p] && enq_rd_i[p] == enq_ra_i[s])
					enq_a_rdy[s] = 1'b0;
				if (enq_we_i[p] && enq_rd_i[p] == enq_rb_i[s])
					enq_b_rdy[s] = 1'b0;
			end
			// an immediate replaces operand b entirely
			if (enq_use_imm_i[s])
				enq_b_rdy[s] = 1'b1;
		end
	end

	assign could_issue_o = valid & ~issued & ~done & arg_a_v & arg_b_v;
	assign done_o        = valid & done;

	// operand fields of the entries picked for each lane
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_op_o[l]      = op[issue_idx_i[l]];
			lane_rd_o[l]      = rd[issue_idx_i[l]];
			lane_ra_o[l]      = ra[issue_idx_i[l]];
			lane_rb_o[l]      = rb[issue_idx_i[l]];
			lane_use_imm_o[l] = use_imm[issue_idx_i[l]];
			lane_imm_o[l]     = imm[issue_idx_i[l]];
		end
	end

	assign head_rd_o = rd[head_idx_i];

	// ==================================================
	// entry updates
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid  <= '0;
			issued <= '0;
			done   <= '0;
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (issue_v_i[l])
					issued[issue_idx_i[l]] <= 1'b1;
				if (wb_v_i[l])
					done[wb_idx_i[l]] <= 1'b1;
			end
			if (retire_i)
				valid[head_idx_i] <= 1'b0;
			// tail entries are always free, so this never meets the retire
			for (int s = 0; s < ENQ_WIDTH; s++) begin
				if (enq_we_i[s]) begin
					valid[enq_idx_i[s]]  <= 1'b1;
					issued[enq_idx_i[s]] <= 1'b0;
					done[enq_idx_i[s]]   <= 1'b0;
				end
			end
		end
	end

	// wakeup first, then enqueue writes take over their own entries
	always_ff @(posedge clk) begin
		for (int e = 0; e < ROB_ENTRIES; e++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (wb_v_i[l] && wb_rd_i[l] == ra[e])
					arg_a_v[e] <= 1'b1;
				if (wb_v_i[l] && wb_rd_i[l] == rb[e])
					arg_b_v[e] <= 1'b1;
			end
		end
		for (int s = 0; s < ENQ_WIDTH; s++) begin
			if (enq_we_i[s]) begin
				op[enq_idx_i[s]]      <= enq_op_i[s];
				rd[enq_idx_i[s]]      <= enq_rd_i[s];
				ra[enq_idx_i[s]]      <= enq_ra_i[s];
				rb[enq_idx_i[s]]      <= enq_rb_i[s];
				use_imm[enq_idx_i[s]] <= enq_use_imm_i[s];
				imm[enq_idx_i[s]]     <= enq_imm_i[s];
				arg_a_v[enq_idx_i[s]] <= enq_a_rdy[s];
				arg_b_v[enq_idx_i[s]] <= enq_b_rdy[s];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/phys_regfile.sv */
// ==================================================
// physical register file with valid bits, two write
// ports and five combinational read ports
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module phys_regfile #(
	parameter int NPREG = 64,
	localparam int PW = $clog2(NPREG),
	localparam int NREAD = 2 * core_pkg::NUM_LANES + 1
) (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic [core_pkg::ENQ_WIDTH-1:0]    clr_v_i,
	input  logic [PW-1:0]                     clr_rd_i [core_pkg::ENQ_WIDTH],
	input  logic [core_pkg::NUM_LANES-1:0]    wr_v_i,
	input  logic [PW-1:0]                     wr_rd_i [core_pkg::NUM_LANES],
	input  core_pkg::value_t                  wr_value_i [core_pkg::NUM_LANES],
	input  logic [PW-1:0]                     rd_addr_i [NREAD],
	output core_pkg::value_t                  rd_value_o [NREAD],
	output logic [NPREG-1:0]                  valid_o
);
	import core_pkg::*;

	value_t           regs [NPREG];
	logic [NPREG-1:0] valid;

	// register zero is never written, so it keeps its reset value and
	// stays valid for good
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int r = 0; r < NPREG; r++)
				regs[r] <= '0;
			valid <= '1;
		end else begin
			// a newly allocated destination waits for its producer
			for (int s = 0; s < ENQ_WIDTH; s++) begin
				if (clr_v_i[s] && clr_rd_i[s] != '0)
					valid[clr_rd_i[s]] <= 1'b0;
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				if (wr_v_i[l] && wr_rd_i[l] != '0) begin
					regs[wr_rd_i[l]]  <= wr_value_i[l];
					valid[wr_rd_i[l]] <= 1'b1;
				end
			end
		end
	end

	// a value written at an edge is visible to reads in the next cycle
	always_comb begin
		for (int p = 0; p < NREAD; p++)
			rd_value_o[p] = regs[rd_addr_i[p]];
	end

	assign valid_o = valid;

endmodule

`default_nettype wire

/* verilog/alu_lane.sv */
// ==================================================
// one integer execution lane: operand latch, ALU
// and registered writeback with its tags
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module alu_lane #(
	parameter int ROB_ENTRIES = 16,
	parameter int NPREG = 64,
	localparam int RW = $clog2(ROB_ENTRIES),
	localparam int PW = $clog2(NPREG)
) (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              issue_v_i,
	input  logic [RW-1:0]     issue_idx_i,
	input  core_pkg::opcode_t op_i,
	input  core_pkg::value_t  a_value_i,
	input  core_pkg::value_t  b_value_i,
	input  logic              use_imm_i,
	input  core_pkg::value_t  imm_i,
	input  logic [PW-1:0]     rd_i,
	output logic              wb_v_o,
	output logic [PW-1:0]     wb_rd_o,
	output logic [RW-1:0]     wb_idx_o,
	output core_pkg::value_t  wb_value_o
);
	import core_pkg::*;

	// execute stage, loaded at the issue edge
	logic          ex_v;
	opcode_t       ex_op;
	value_t        ex_a;
	value_t        ex_b;
	logic [PW-1:0] ex_rd;
	logic [RW-1:0] ex_idx;
	value_t        result;

	always_ff @(posedge clk) begin
		if (reset_i)
			ex_v <= 1'b0;
		else
			ex_v <= issue_v_i;
	end

	// the immediate takes the place of operand b when flagged
	always_ff @(posedge clk) begin
		if (issue_v_i) begin
			ex_op  <= op_i;
			ex_a   <= a_value_i;
			ex_b   <= use_imm_i ? imm_i : b_value_i;
			ex_rd  <= rd_i;
			ex_idx <= issue_idx_i;
		end
	end

	always_comb begin
		case (ex_op)
			OP_ADD:  result = ex_a + ex_b;
			OP_SUB:  result = ex_a - ex_b;
			OP_AND:  result = ex_a & ex_b;
			OP_OR:   result = ex_a | ex_b;
			OP_XOR:  result = ex_a ^ ex_b;
			// only the low five bits of b count as a shift amount
			OP_SLL:  result = ex_a << ex_b[4:0];
			default: result = '0;
		endcase
	end

	// ==================================================
	// writeback register
	// ==================================================

	// wb_v_o lasts one cycle per issue, and a new issue can already be in
	// the execute stage behind it
	always_ff @(posedge clk) begin
		if (reset_i)
			wb_v_o <= 1'b0;
		else
			wb_v_o <= ex_v;
	end

	always_ff @(posedge clk) begin
		if (ex_v) begin
			wb_rd_o    <= ex_rd;
			wb_idx_o   <= ex_idx;
			wb_value_o <= result;
		end
	end

endmodule

`default_nettype wire

/* verilog/issue_core.sv */
// ==================================================
// issue core top: reorder buffer control and entries,
// physical register file and two ALU lanes
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module issue_core #(
	parameter int ROB_ENTRIES = 16,
	parameter int NPREG = 64,
	localparam int RW = $clog2(ROB_ENTRIES),
	localparam int PW = $clog2(NPREG)
) (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic [core_pkg::ENQ_WIDTH-1:0]    enq_v_i,
	input  core_pkg::opcode_t                 enq_op_i [core_pkg::ENQ_WIDTH],
	input  logic [PW-1:0]                     enq_rd_i [core_pkg::ENQ_WIDTH],
	input  logic [PW-1:0]                     enq_ra_i [core_pkg::ENQ_WIDTH],
	input  logic [PW-1:0]                     enq_rb_i [core_pkg::ENQ_WIDTH],
	input  logic [core_pkg::ENQ_WIDTH-1:0]    enq_use_imm_i,
	input  core_pkg::value_t                  enq_imm_i [core_pkg::ENQ_WIDTH],
	output logic                              enq_ready_o,
	output logic                              commit_v_o,
	output logic [PW-1:0]                     commit_rd_o,
	output core_pkg::value_t                  commit_value_o
);
	import core_pkg::*;

	// read port 2*l and 2*l+1 serve lane l, the last one serves commit
	localparam int NREAD = 2 * NUM_LANES + 1;

	// control between rob_ctrl and rob_entries
	logic [ENQ_WIDTH-1:0]   enq_we;
	logic [RW-1:0]          enq_idx [ENQ_WIDTH];
	logic [ROB_ENTRIES-1:0] could_issue;
	logic [ROB_ENTRIES-1:0] done;
	logic [NUM_LANES-1:0]   issue_v;
	logic [RW-1:0]          issue_idx [NUM_LANES];
	logic [RW-1:0]          head_idx;
	logic                   retire;
	logic [PW-1:0]          head_rd;

	// selected entry fields per lane
	opcode_t                lane_op [NUM_LANES];
	logic [PW-1:0]          lane_rd [NUM_LANES];
	logic [PW-1:0]          lane_ra [NUM_LANES];
	logic [PW-1:0]          lane_rb [NUM_LANES];
	logic [NUM_LANES-1:0]   lane_use_imm;
	value_t                 lane_imm [NUM_LANES];

	// register file ports and the writeback buses
	logic [NPREG-1:0]       rf_valid;
	logic [PW-1:0]          rf_addr [NREAD];
	value_t                 rf_value [NREAD];
	logic [NUM_LANES-1:0]   wb_v;
	logic [PW-1:0]          wb_rd [NUM_LANES];
	logic [RW-1:0]          wb_idx [NUM_LANES];
	value_t                 wb_value [NUM_LANES];

	rob_ctrl #(
		.ROB_ENTRIES(ROB_ENTRIES)
	) rob_ctrl_inst (
		.clk           (clk),
		.reset_i       (reset_i),
		.enq_v_i       (enq_v_i),
		.could_issue_i (could_issue),
		.done_i        (done),
		.enq_ready_o   (enq_ready_o),
		.enq_we_o      (enq_we),
		.enq_idx_o     (enq_idx),
		.issue_v_o     (issue_v),
		.issue_idx_o   (issue_idx),
		.head_idx_o    (head_idx),
		.retire_o      (retire)
	);

	rob_entries #(
		.ROB_ENTRIES(ROB_ENTRIES),
		.NPREG      (NPREG)
	) rob_entries_inst (
		.clk            (clk),
		.reset_i        (reset_i),
		.enq_we_i       (enq_we),
		.enq_idx_i      (enq_idx),
		.enq_op_i       (enq_op_i),
		.enq_rd_i       (enq_rd_i),
		.enq_ra_i       (enq_ra_i),
		.enq_rb_i       (enq_rb_i),
		.enq_use_imm_i  (enq_use_imm_i),
		.enq_imm_i      (enq_imm_i),
		.rf_valid_i     (rf_valid),
		.issue_v_i      (issue_v),
		.issue_idx_i    (issue_idx),
		.wb_v_i         (wb_v),
		.wb_rd_i        (wb_rd),
		.wb_idx_i       (wb_idx),
		.retire_i       (retire),
		.head_idx_i     (head_idx),
		.could_issue_o  (could_issue),
		.done_o         (done),
		.lane_op_o      (lane_op),
		.lane_rd_o      (lane_rd),
		.lane_ra_o      (lane_ra),
		.lane_rb_o      (lane_rb),
		.lane_use_imm_o (lane_use_imm),
		.lane_imm_o     (lane_imm),
		.head_rd_o      (head_rd)
	);

	// enqueue invalidates the destination in the same cycle it is accepted
	phys_regfile #(
		.NPREG(NPREG)
	) phys_regfile_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.clr_v_i    (enq_we),
		.clr_rd_i   (enq_rd_i),
		.wr_v_i     (wb_v),
		.wr_rd_i    (wb_rd),
		.wr_value_i (wb_value),
		.rd_addr_i  (rf_addr),
		.rd_value_o (rf_value),
		.valid_o    (rf_valid)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		assign rf_addr[2*g]   = lane_ra[g];
		assign rf_addr[2*g+1] = lane_rb[g];

		alu_lane #(
			.ROB_ENTRIES(ROB_ENTRIES),
			.NPREG      (NPREG)
		) alu_lane_inst (
			.clk         (clk),
			.reset_i     (reset_i),
			.issue_v_i   (issue_v[g]),
			.issue_idx_i (issue_idx[g]),
			.op_i        (lane_op[g]),
			.a_value_i   (rf_value[2*g]),
			.b_value_i   (rf_value[2*g+1]),
			.use_imm_i   (lane_use_imm[g]),
			.imm_i       (lane_imm[g]),
			.rd_i        (lane_rd[g]),
			.wb_v_o      (wb_v[g]),
			.wb_rd_o     (wb_rd[g]),
			.wb_idx_o    (wb_idx[g]),
			.wb_value_o  (wb_value[g])
		);
	end

	// the head's result is already in the register file once it is done
	assign rf_addr[NREAD-1] = head_rd;
	assign commit_v_o       = retire;
	assign commit_rd_o      = head_rd;
	assign commit_value_o   = rf_value[NREAD-1];

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// ==================================================
// testbench clock source, free running from time zero
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	// low for the first half period so the first rising edge is at PERIOD_NS/2
	initial clk_o = 1'b0;

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb/issue_core_tb.sv */
// ==================================================
// testbench of the issue core with a program-order
// golden model, commit checks and six tests
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;
	import core_pkg::*;

	localparam int ROB_ENTRIES = 16;
	localparam int NPREG = 64;
	localparam int PW = $clog2(NPREG);
	localparam int DRIVE_DELAY = 1;
	localparam int WAIT_LIMIT = 200;

	logic                 clk;
	logic                 reset_i;
	logic [ENQ_WIDTH-1:0] enq_v;
	opcode_t              enq_op [ENQ_WIDTH];
	logic [PW-1:0]        enq_rd [ENQ_WIDTH];
	logic [PW-1:0]        enq_ra [ENQ_WIDTH];
	logic [PW-1:0]        enq_rb [ENQ_WIDTH];
	logic [ENQ_WIDTH-1:0] enq_use_imm;
	value_t               enq_imm [ENQ_WIDTH];
	logic                 enq_ready;
	logic                 commit_v;
	logic [PW-1:0]        commit_rd;
	value_t               commit_value;

	// golden model in program order and the commits it still expects
	value_t        model_regs [NPREG];
	logic [PW-1:0] exp_rd_q [$];
	value_t        exp_val_q [$];
	// round-robin destination pointer and the last eight destinations
	logic [PW-1:0] dest_ptr;
	logic [PW-1:0] recent [8];
	int            recent_cnt;
	int            recent_wr;
	logic [31:0]   rng_state;
	logic          saw_stall;
	int            accepted;
	int            commits;
	int            checks;
	int            errors;
	int            errors_mark;
	int            tests_run;

	tb_clock #(
		.PERIOD_NS(40)
	) tb_clock_inst (
		.clk_o(clk)
	);

	issue_core #(
		.ROB_ENTRIES(ROB_ENTRIES),
		.NPREG      (NPREG)
	) issue_core_inst (
		.clk            (clk),
		.reset_i        (reset_i),
		.enq_v_i        (enq_v),
		.enq_op_i       (enq_op),
		.enq_rd_i       (enq_rd),
		.enq_ra_i       (enq_ra),
		.enq_rb_i       (enq_rb),
		.enq_use_imm_i  (enq_use_imm),
		.enq_imm_i      (enq_imm),
		.enq_ready_o    (enq_ready),
		.commit_v_o     (commit_v),
		.commit_rd_o    (commit_rd),
		.commit_value_o (commit_value)
	);

	// ==================================================
	// helpers
	// ==================================================

	// low LCG bits have short periods so only the upper half is handed out
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {16'd0, rng_state[31:16]};
	endfunction

	function automatic value_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi[15:0], lo[15:0]};
	endfunction

	// ALU semantics as the ISA defines them with b mod 32 as the shift amount
	function automatic value_t expected_result(input opcode_t op, input value_t a,
			input value_t b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			default: return '0;
		endcase
	endfunction

	// destinations cycle through 1..63 and are remembered as future sources
	function automatic logic [PW-1:0] alloc_dest();
		logic [PW-1:0] rd;
		rd = dest_ptr;
		dest_ptr = (dest_ptr == PW'(NPREG - 1)) ? PW'(1) : dest_ptr + PW'(1);
		recent[recent_wr] = rd;
		recent_wr = (recent_wr + 1) % 8;
		if (recent_cnt < 8)
			recent_cnt++;
		return rd;
	endfunction

	// mostly a recent destination and sometimes register zero
	function automatic logic [PW-1:0] pick_source();
		logic [31:0] r;
		r = next_rand();
		if (recent_cnt == 0 || r % 5 == 0)
			return '0;
		return recent[r % recent_cnt];
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("Something failed");
		$finish;
	endtask

	task automatic fill_slot(input int s, input opcode_t op, input logic [PW-1:0] ra,
			input logic [PW-1:0] rb, input logic use_imm, input value_t imm);
		enq_v[s]       = 1'b1;
		enq_op[s]      = op;
		enq_rd[s]      = alloc_dest();
		enq_ra[s]      = ra;
		enq_rb[s]      = rb;
		enq_use_imm[s] = use_imm;
		enq_imm[s]     = imm;
	endtask

	// holds the slots until enq_ready_o lets them in and then books them in the model
	task automatic push_group();
		int     n;
		value_t a;
		value_t b;
		value_t r;
		n = 0;
		@(negedge clk);
		while (!enq_ready) begin
			saw_stall = 1'b1;
			n++;
			if (n > WAIT_LIMIT)
				abort_on_timeout("enq_ready_o stayed low");
			@(negedge clk);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		for (int s = 0; s < ENQ_WIDTH; s++) begin
			if (enq_v[s]) begin
				a = model_regs[enq_ra[s]];
				b = enq_use_imm[s] ? enq_imm[s] : model_regs[enq_rb[s]];
				r = expected_result(enq_op[s], a, b);
				model_regs[enq_rd[s]] = r;
				exp_rd_q.push_back(enq_rd[s]);
				exp_val_q.push_back(r);
				accepted++;
			end
		end
		enq_v = '0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_rd_q.size() != 0) begin
			@(posedge clk);
			#DRIVE_DELAY;
			n++;
			if (n > WAIT_LIMIT)
				abort_on_timeout("outstanding micro-ops were never committed");
		end
	endtask

	task automatic check_counts();
		checks++;
		assert (commits == accepted) else begin
			$display("ERR %0t commit count got %0d expected %0d", $time, commits, accepted);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - errors_mark);
		errors_mark = errors;
		tests_run++;
	endtask

	// ==================================================
	// commit checker
	// ==================================================

	// outputs settle long before the falling edge
	always @(negedge clk) begin
		logic [PW-1:0] want_rd;
		value_t        want_val;
		if (!reset_i && commit_v) begin
			checks++;
			// every pulse counts, including one that nothing was waiting for
			commits++;
			assert (exp_rd_q.size() != 0) else begin
				$display("commit at %0t with no micro-op outstanding", $time);
				errors++;
			end
			if (exp_rd_q.size() != 0) begin
				want_rd  = exp_rd_q.pop_front();
				want_val = exp_val_q.pop_front();
				assert (commit_rd == want_rd) else begin
					$display("ERR %0t commit_rd_o got %0d expected %0d", $time, commit_rd,
						want_rd);
					errors++;
				end
				assert (commit_value == want_val) else begin
					$display("ERR %0t commit_value_o got %h expected %h", $time,
						commit_value, want_val);
					errors++;
				end
			end
		end
	end

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		logic [PW-1:0] prev;
		logic [31:0]   v;
		int            sent;
		reset_i     = 1'b1;
		enq_v       = '0;
		enq_use_imm = '0;
		for (int s = 0; s < ENQ_WIDTH; s++) begin
			enq_op[s]  = OP_ADD;
			enq_rd[s]  = '0;
			enq_ra[s]  = '0;
			enq_rb[s]  = '0;
			enq_imm[s] = '0;
		end
		for (int r = 0; r < NPREG; r++)
			model_regs[r] = '0;
		dest_ptr    = PW'(1);
		recent_cnt  = 0;
		recent_wr   = 0;
		rng_state   = 32'd60;
		saw_stall   = 1'b0;
		accepted    = 0;
		commits     = 0;
		checks      = 0;
		errors      = 0;
		errors_mark = 0;
		tests_run   = 0;

		repeat (10) @(posedge clk);
		#DRIVE_DELAY;
		reset_i = 1'b0;

		// an empty core accepts and commits nothing
		repeat (5) begin
			@(negedge clk);
			checks += 2;
			assert (enq_ready === 1'b1) else begin
				$display("ERR %0t enq_ready_o got %b expected 1", $time, enq_ready);
				errors++;
			end
			assert (commit_v === 1'b0) else begin
				$display("ERR %0t commit_v_o got %b expected 0", $time, commit_v);
				errors++;
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
		end_test("reset");

		// every opcode first from registers and then with an immediate
		for (int i = 0; i < 12; i++) begin
			fill_slot(0, opcode_t'(i % 6), pick_source(), pick_source(), i >= 6, rand_word());
			push_group();
		end
		wait_drained();
		end_test("independent");

		// each one waits for the writeback of the one before
		prev = pick_source();
		for (int i = 0; i < 10; i++) begin
			fill_slot(0, opcode_t'(next_rand() % 6), prev, prev, i[0], rand_word());
			prev = enq_rd[0];
			push_group();
		end
		wait_drained();
		end_test("chain");

		// slot 1 consumes slot 0's result in the same enqueue cycle
		for (int i = 0; i < 6; i++) begin
			fill_slot(0, opcode_t'(next_rand() % 6), pick_source(), pick_source(), 1'b0,
				rand_word());
			fill_slot(1, opcode_t'(i % 6), enq_rd[0], enq_rd[0], i[0], rand_word());
			push_group();
		end
		wait_drained();
		end_test("pairs");

		// two per cycle against one retire per cycle fills the ROB
		saw_stall = 1'b0;
		for (int i = 0; i < 24; i++) begin
			fill_slot(0, opcode_t'(next_rand() % 6), pick_source(), pick_source(), 1'b1,
				rand_word());
			fill_slot(1, opcode_t'(next_rand() % 6), pick_source(), pick_source(), 1'b0,
				rand_word());
			push_group();
		end
		checks++;
		assert (saw_stall) else begin
			$display("enq_ready_o never fell while the ROB was filling");
			errors++;
		end
		wait_drained();
		check_counts();
		end_test("backpressure");

		sent = 0;
		while (sent < 200) begin
			v = next_rand() % 4;
			if (sent == 199 && v == 3)
				v = 1;
			if (v == 0) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end else begin
				for (int s = 0; s < ENQ_WIDTH; s++) begin
					if (v[s]) begin
						fill_slot(s, opcode_t'(next_rand() % 6), pick_source(), pick_source(),
							next_rand() % 3 == 0, rand_word());
						sent++;
					end
				end
				push_group();
			end
		end
		wait_drained();
		check_counts();
		end_test("random");

		$display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/core_pkg.sv
verilog/rob_ctrl.sv
verilog/rob_entries.sv
verilog/phys_regfile.sv
verilog/alu_lane.sv
verilog/issue_core.sv
tb/tb_clock.sv
tb/issue_core_tb.sv

/* run.sh */
#!/bin/sh
# compile the issue core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module issue_core_tb \
	-f flist.f -o issue_core_sim || exit 1
out=$(./obj_dir/issue_core_sim)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1
